/* rtl/ttlCpuPkg.sv */
`default_nettype none

package ttlCpuPkg;

   localparam int dataWidth = 8;
   localparam int pcWidth = 8;
   localparam int progDepth = 2 ** pcWidth;
   localparam int ramDepth = 16;
   localparam int ramAddrWidth = $clog2(ramDepth);

   // Qualifier bit positions inside the instruction byte
   localparam int carryQualBit = 7;
   localparam int zeroQualBit = 3;

   // Bus sources, in the order of the bits 2..0 field
   typedef enum logic [2:0] {
      srcRom   = 3'd0,  // Immediate byte following the opcode
      srcZero  = 3'd1,
      srcA     = 3'd2,
      srcB     = 3'd3,
      srcX     = 3'd4,
      srcRam   = 3'd5,  // RAM addressed by X
      srcSum   = 3'd6,  // A plus or minus B
      srcShift = 3'd7   // A shifted right by one
   } sourceSel;

   // Destinations, in the order of the bits 6..4 field
   typedef enum logic [2:0] {
      destNone  = 3'd0,
      destPc    = 3'd1,  // Conditional jump
      destA     = 3'd2,
      destB     = 3'd3,
      destX     = 3'd4,
      destRam   = 3'd5,
      destQ     = 3'd6,
      destNone2 = 3'd7
   } destSel;

   typedef enum logic {
      phaseFetch   = 1'b0,
      phaseExecute = 1'b1
   } phaseType;

endpackage

`default_nettype wire

/* rtl/programStore.sv */
`timescale 1ns/10ps
`default_nettype none

module programStore (
   input  wire                                clk,
   input  wire                                reset,
   input  wire                                progWrite,
   input  wire  [ttlCpuPkg::pcWidth-1:0]      progAddr,
   input  wire  [ttlCpuPkg::dataWidth-1:0]    progData,
   input  wire  [ttlCpuPkg::pcWidth-1:0]      pc,
   output logic [ttlCpuPkg::dataWidth-1:0]    romData
);

   import ttlCpuPkg::*;

   logic [dataWidth-1:0] mem [progDepth];

   always_ff @(posedge clk) begin
      if (progWrite) begin
         mem[progAddr] <= progData;
      end
   end

   // The sequencer sees the byte at pc in the same cycle
   assign romData = mem[pc];

   // Loading is only allowed while the core is held in reset
   writeOnlyInReset: assert property (@(posedge clk) progWrite |-> reset)
      else $error("Program store written while the core is running");

endmodule

`default_nettype wire

/* rtl/sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module sequencer (
   input  wire                                clk,
   input  wire                                reset,
   input  wire  [ttlCpuPkg::dataWidth-1:0]    romData,
   input  wire  [ttlCpuPkg::dataWidth-1:0]    busData,
   input  wire                                loadPc,
   input  wire                                stall,
   input  wire                                immediate,
   output logic [ttlCpuPkg::pcWidth-1:0]      pc,
   output logic [ttlCpuPkg::dataWidth-1:0]    ir,
   output ttlCpuPkg::phaseType                phase
);

   import ttlCpuPkg::*;

   always_ff @(posedge clk) begin
      if (reset) begin
         phase <= phaseFetch;
         pc    <= '0;
      end else if (phase == phaseFetch) begin
         phase <= phaseExecute;
         pc    <= pc + 1'b1;  // Step past the opcode
      end else if (!stall) begin
         phase <= phaseFetch;
         if (loadPc) begin
            pc <= busData;
         end else if (immediate) begin
            pc <= pc + 1'b1;  // Skip the immediate byte
         end
      end
   end

   // The opcode is captured at the end of fetch and held through execute
   always_ff @(posedge clk) begin
      if (phase == phaseFetch) begin
         ir <= romData;
      end
   end

   // A stalled execute repeats on the next cycle
   phaseHeldInStall: assert property (
      @(posedge clk) disable iff (reset)
      stall |=> $stable(phase) && (phase == phaseExecute))
      else $error("Phase moved during a stall");

endmodule

`default_nettype wire

/* rtl/controlDecode.sv */
`timescale 1ns/10ps
`default_nettype none

module controlDecode (
   input  wire  [ttlCpuPkg::dataWidth-1:0]    ir,
   input  wire  ttlCpuPkg::phaseType          phase,
   input  wire                                aIsZero,
   input  wire                                flagCarry,
   input  wire                                outFull,
   output ttlCpuPkg::sourceSel                source,
   output logic                               loadA,
   output logic                               loadB,
   output logic                               loadX,
   output logic                               storeRam,
   output logic                               loadQ,
   output logic                               loadPc,
   output logic                               doSubtract,
   output logic                               updateCarry,
   output logic                               immediate,
   output logic                               stall
);

   import ttlCpuPkg::*;

   logic   carryQual;
   logic   zeroQual;
   destSel dest;
   logic   active;
   logic   jumpOk;

   assign carryQual = ir[carryQualBit];
   assign zeroQual  = ir[zeroQualBit];
   assign dest      = destSel'(ir[6:4]);
   assign source    = sourceSel'(ir[2:0]);

   // Output writes wait for the port to drain
   assign stall  = (phase == phaseExecute) && (dest == destQ) && outFull;
   assign active = (phase == phaseExecute) && !stall;

   // Each set qualifier must be met, a clear one is ignored
   assign jumpOk = (!zeroQual || aIsZero) && (!carryQual || flagCarry);

   // Bit 3 means subtract except on jumps
   assign doSubtract  = zeroQual && (dest != destPc);
   assign updateCarry = active && ((source == srcSum) || (source == srcShift));
   assign immediate   = active && (source == srcRom);

   always_comb begin
      loadA    = 1'b0;
      loadB    = 1'b0;
      loadX    = 1'b0;
      storeRam = 1'b0;
      loadQ    = 1'b0;
      loadPc   = 1'b0;
      if (active) begin
         case (dest)
            destPc:  loadPc   = jumpOk;
            destA:   loadA    = 1'b1;
            destB:   loadB    = 1'b1;
            destX:   loadX    = 1'b1;
            destRam: storeRam = 1'b1;
            destQ:   loadQ    = 1'b1;
            default: ;  // destNone and destNone2 only read the bus
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/dataPath.sv */
`timescale 1ns/10ps
`default_nettype none

module dataPath (
   input  wire                                clk,
   input  wire                                reset,
   input  wire  ttlCpuPkg::sourceSel          source,
   input  wire  [ttlCpuPkg::dataWidth-1:0]    romData,
   input  wire                                loadA,
   input  wire                                loadB,
   input  wire                                loadX,
   input  wire                                storeRam,
   input  wire                                doSubtract,
   input  wire                                updateCarry,
   output logic [ttlCpuPkg::dataWidth-1:0]    busData,
   output logic                               aIsZero,
   output logic                               flagCarry
);

   import ttlCpuPkg::*;

   logic [dataWidth-1:0]    regA;
   logic [dataWidth-1:0]    regB;
   logic [dataWidth-1:0]    regX;
   logic [dataWidth-1:0]    ram [ramDepth];
   logic [ramAddrWidth-1:0] ramAddr;
   logic [dataWidth-1:0]    operandB;
   logic [dataWidth:0]      aluResult;
   logic [dataWidth-1:0]    shiftResult;
   logic                    carryIn;

   assign ramAddr = regX[ramAddrWidth-1:0];  // Upper bits of X are ignored

   // Subtraction is A plus the inverse of B plus one
   assign operandB  = doSubtract ? ~regB : regB;
   assign aluResult = {1'b0, regA} + {1'b0, operandB} + {{dataWidth{1'b0}}, doSubtract};

   assign shiftResult = {1'b0, regA[dataWidth-1:1]};

   // On subtraction a set carry means no borrow
   assign carryIn = (source == srcShift) ? regA[0] : aluResult[dataWidth];

   always_comb begin
      case (source)
         srcRom:   busData = romData;
         srcZero:  busData = '0;
         srcA:     busData = regA;
         srcB:     busData = regB;
         srcX:     busData = regX;
         srcRam:   busData = ram[ramAddr];
         srcSum:   busData = aluResult[dataWidth-1:0];
         srcShift: busData = shiftResult;
         default:  busData = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         regA      <= '0;
         regB      <= '0;
         regX      <= '0;
         flagCarry <= 1'b0;
      end else begin
         if (loadA) begin
            regA <= busData;
         end
         if (loadB) begin
            regB <= busData;
         end
         if (loadX) begin
            regX <= busData;
         end
         if (updateCarry) begin
            flagCarry <= carryIn;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (storeRam) begin
         ram[ramAddr] <= busData;
      end
   end

   // Zero qualifier for jumps
   assign aIsZero = (regA == '0);

endmodule

`default_nettype wire

/* rtl/outputPort.sv */
`timescale 1ns/10ps
`default_nettype none

module outputPort (
   input  wire                                clk,
   input  wire                                reset,
   input  wire                                loadQ,
   input  wire  [ttlCpuPkg::dataWidth-1:0]    busData,
   input  wire                                outReady,
   output logic                               outValid,
   output logic [ttlCpuPkg::dataWidth-1:0]    outData,
   output logic                               outFull
);

   import ttlCpuPkg::*;

   always_ff @(posedge clk) begin
      if (reset) begin
         outValid <= 1'b0;
      end else if (loadQ) begin
         outValid <= 1'b1;  // A load may refill the slot in the cycle it drains
      end else if (outReady) begin
         outValid <= 1'b0;
      end
   end

   // Q register
   always_ff @(posedge clk) begin
      if (loadQ) begin
         outData <= busData;
      end
   end

   assign outFull = outValid && !outReady;

   qHeldUntilAccepted: assert property (
      @(posedge clk) disable iff (reset)
      outValid && !outReady |=> outValid && $stable(outData))
      else $error("Output byte changed before it was accepted");

   // The decoder must hold off a write into a full port
   noLoadWhenFull: assert property (
      @(posedge clk) disable iff (reset) outFull |-> !loadQ)
      else $error("Output port loaded while full");

endmodule

`default_nettype wire

/* rtl/ttlCpu.sv */
`timescale 1ns/10ps
`default_nettype none

module ttlCpu (
   input  wire                                clk,
   input  wire                                reset,
   input  wire                                progWrite,
   input  wire  [ttlCpuPkg::pcWidth-1:0]      progAddr,
   input  wire  [ttlCpuPkg::dataWidth-1:0]    progData,
   input  wire                                outReady,
   output logic                               outValid,
   output logic [ttlCpuPkg::dataWidth-1:0]    outData
);

   import ttlCpuPkg::*;

   logic [pcWidth-1:0]   pc;
   logic [dataWidth-1:0] romData;
   logic [dataWidth-1:0] ir;
   logic [dataWidth-1:0] busData;
   phaseType             phase;
   sourceSel             source;
   logic                 loadA;
   logic                 loadB;
   logic                 loadX;
   logic                 storeRam;
   logic                 loadQ;
   logic                 loadPc;
   logic                 doSubtract;
   logic                 updateCarry;
   logic                 immediate;
   logic                 stall;
   logic                 aIsZero;
   logic                 flagCarry;
   logic                 outFull;

   programStore i_programStore (
      .clk       (clk),
      .reset     (reset),
      .progWrite (progWrite),
      .progAddr  (progAddr),
      .progData  (progData),
      .pc        (pc),
      .romData   (romData)
   );

   sequencer i_sequencer (
      .clk       (clk),
      .reset     (reset),
      .romData   (romData),
      .busData   (busData),
      .loadPc    (loadPc),
      .stall     (stall),
      .immediate (immediate),
      .pc        (pc),
      .ir        (ir),
      .phase     (phase)
   );

   controlDecode i_controlDecode (
      .ir          (ir),
      .phase       (phase),
      .aIsZero     (aIsZero),
      .flagCarry   (flagCarry),
      .outFull     (outFull),
      .source      (source),
      .loadA       (loadA),
      .loadB       (loadB),
      .loadX       (loadX),
      .storeRam    (storeRam),
      .loadQ       (loadQ),
      .loadPc      (loadPc),
      .doSubtract  (doSubtract),
      .updateCarry (updateCarry),
      .immediate   (immediate),
      .stall       (stall)
   );

   dataPath i_dataPath (
      .clk         (clk),
      .reset       (reset),
      .source      (source),
      .romData     (romData),
      .loadA       (loadA),
      .loadB       (loadB),
      .loadX       (loadX),
      .storeRam    (storeRam),
      .doSubtract  (doSubtract),
      .updateCarry (updateCarry),
      .busData     (busData),
      .aIsZero     (aIsZero),
      .flagCarry   (flagCarry)
   );

   outputPort i_outputPort (
      .clk      (clk),
      .reset    (reset),
      .loadQ    (loadQ),
      .busData  (busData),
      .outReady (outReady),
      .outValid (outValid),
      .outData  (outData),
      .outFull  (outFull)
   );

endmodule

`default_nettype wire

/* tb/ttlCpuTb.sv */
`timescale 1ns/10ps
`default_nettype none

module ttlCpuTb;

   import ttlCpuPkg::*;

   localparam int numTests = 6;

   logic                 clk = 1'b0;
   logic                 reset;
   logic                 progWrite;
   logic [pcWidth-1:0]   progAddr;
   logic [dataWidth-1:0] progData;
   logic                 outReady = 1'b0;
   logic                 outValid;
   logic [dataWidth-1:0] outData;

   logic [7:0] prog [256];
   int         progLen;
   logic [7:0] expOut [$];
   int         rxCount = 0;
   int         errors = 0;
   int         checks = 0;
   int         cycles = 0;
   int         limit = 0;
   logic       readyMode = 1'b0;
   logic       holdReady = 1'b0;
   logic [3:0] stretchCnt = '0;
   logic [31:0] rnd;
   integer     seed = 23;
   string      testNames [numTests] = '{"moves", "alu", "ram", "jumps", "backpressure", "zero"};

   ttlCpu i_ttlCpu (
      .clk       (clk),
      .reset     (reset),
      .progWrite (progWrite),
      .progAddr  (progAddr),
      .progData  (progData),
      .outReady  (outReady),
      .outValid  (outValid),
      .outData   (outData)
   );

   always #5 clk = ~clk;

   task automatic checkValue(input string name, input logic [7:0] got, input logic [7:0] exp);
      checks++;
      if (got !== exp) begin
         $display("Mismatch %s: got 0x%02h, expected 0x%02h", name, got, exp);
         errors++;
      end
   endtask

   function automatic logic [7:0] instr(destSel d, sourceSel s, logic q3, logic q7);
      return {q7, 3'(d), q3, 3'(s)};
   endfunction

   task automatic emit(input logic [7:0] value);
      prog[progLen] = value;
      progLen++;
   endtask

   task automatic loadImm(input destSel d, input logic [7:0] value);
      emit(instr(d, srcRom, 1'b0, 1'b0));
      emit(value);
   endtask

   task automatic move(input destSel d, input sourceSel s);
      emit(instr(d, s, 1'b0, 1'b0));
   endtask

   task automatic jumpTo(input logic [7:0] target, input logic q3, input logic q7);
      emit(instr(destPc, srcRom, q3, q7));
      emit(target);
   endtask

   // Target byte is filled in later by patchHere
   task automatic jumpFwd(input logic q3, input logic q7, output int slot);
      emit(instr(destPc, srcRom, q3, q7));
      slot = progLen;
      emit(8'h00);
   endtask

   task automatic patchHere(input int slot);
      prog[slot] = 8'(progLen);
   endtask

   task automatic halt();
      jumpTo(8'(progLen), 1'b0, 1'b0);  // Jump to itself
   endtask

   task automatic buildProgram(input int idx);
      int slot;
      int loop;
      progLen = 0;
      for (int i = 0; i < 256; i++) begin
         prog[i] = 8'h00;
      end
      case (idx)
         0: begin
            loadImm(destA, 8'h5A);
            move(destB, srcA);
            move(destQ, srcB);
            loadImm(destX, 8'hC3);
            move(destQ, srcX);
            move(destA, srcX);
            move(destQ, srcA);
            loadImm(destQ, 8'h81);
         end
         1: begin
            loadImm(destA, 8'd200);
            loadImm(destB, 8'd100);
            move(destQ, srcSum);  // Overflows and sets carry
            jumpFwd(1'b0, 1'b1, slot);
            loadImm(destQ, 8'hEE);
            patchHere(slot);
            move(destQ, srcA);
            loadImm(destA, 8'd10);
            loadImm(destB, 8'd3);
            emit(instr(destA, srcSum, 1'b1, 1'b0));
            move(destQ, srcA);
            loadImm(destB, 8'd20);
            emit(instr(destA, srcSum, 1'b1, 1'b0));  // Borrow clears carry
            move(destQ, srcA);
            jumpFwd(1'b0, 1'b1, slot);
            loadImm(destQ, 8'h11);
            patchHere(slot);
            loadImm(destA, 8'h05);
            move(destA, srcShift);
            move(destQ, srcA);
            jumpFwd(1'b0, 1'b1, slot);
            loadImm(destQ, 8'hEE);
            patchHere(slot);
            move(destA, srcShift);
            jumpFwd(1'b0, 1'b1, slot);
            loadImm(destQ, 8'h33);
            patchHere(slot);
         end
         2: begin
            loadImm(destX, 8'h03);
            loadImm(destRam, 8'h44);
            loadImm(destX, 8'h07);
            loadImm(destRam, 8'h77);
            loadImm(destX, 8'h13);  // Same RAM address as 3
            move(destQ, srcRam);
            loadImm(destRam, 8'h99);
            loadImm(destX, 8'h03);
            move(destQ, srcRam);
            loadImm(destX, 8'h07);
            move(destA, srcRam);
            move(destQ, srcA);
         end
         3: begin
            loadImm(destA, 8'h01);
            jumpFwd(1'b1, 1'b0, slot);
            loadImm(destQ, 8'h01);
            patchHere(slot);
            loadImm(destA, 8'd5);
            loadImm(destB, 8'd1);
            loop = progLen;
            move(destQ, srcA);
            emit(instr(destA, srcSum, 1'b1, 1'b0));
            jumpFwd(1'b1, 1'b0, slot);
            jumpTo(8'(loop), 1'b0, 1'b0);
            patchHere(slot);
            loadImm(destQ, 8'hD0);
            jumpFwd(1'b1, 1'b1, slot);
            loadImm(destQ, 8'hEE);
            patchHere(slot);
         end
         4: begin
            loadImm(destA, 8'd12);
            loadImm(destB, 8'd1);
            loop = progLen;
            move(destQ, srcA);
            move(destQ, srcShift);  // Back to back outputs
            emit(instr(destA, srcSum, 1'b1, 1'b0));
            jumpFwd(1'b1, 1'b0, slot);
            jumpTo(8'(loop), 1'b0, 1'b0);
            patchHere(slot);
         end
         default: begin
            move(destQ, srcZero);
            loadImm(destA, 8'h77);
            move(destA, srcZero);
            jumpFwd(1'b1, 1'b0, slot);
            loadImm(destQ, 8'hEE);
            patchHere(slot);
            move(destQ, srcA);
            loadImm(destQ, 8'h5C);
         end
      endcase
      halt();
   endtask

   // Instruction set model that returns the executed instruction count
   function automatic int runModel();
      logic [7:0] a;
      logic [7:0] b;
      logic [7:0] x;
      logic [7:0] pc;
      logic [7:0] at;
      logic [7:0] op;
      logic [7:0] bus;
      logic [7:0] ram [16];
      logic [8:0] wide;
      logic       carry;
      logic       sub;
      logic       jump;
      logic       done;
      destSel     d;
      sourceSel   s;
      int         steps;
      a = 8'h00;
      b = 8'h00;
      x = 8'h00;
      pc = 8'h00;
      bus = 8'h00;
      carry = 1'b0;
      done = 1'b0;
      steps = 0;
      for (int i = 0; i < 16; i++) begin
         ram[i] = 8'h00;
      end
      expOut.delete();
      while (!done && steps < 2000) begin
         at = pc;
         op = prog[pc];
         pc = pc + 8'd1;
         steps++;
         d = destSel'(op[6:4]);
         s = sourceSel'(op[2:0]);
         sub = op[3] && (d != destPc);
         jump = (!op[3] || (a == 8'h00)) && (!op[7] || carry);  // Flags before this instruction
         case (s)
            srcRom: begin
               bus = prog[pc];
               pc = pc + 8'd1;
            end
            srcZero: bus = 8'h00;
            srcA:    bus = a;
            srcB:    bus = b;
            srcX:    bus = x;
            srcRam:  bus = ram[x[3:0]];
            srcSum: begin
               if (sub) begin
                  bus = a - b;
                  carry = (a >= b);  // Set when there is no borrow
               end else begin
                  wide = {1'b0, a} + {1'b0, b};
                  bus = wide[7:0];
                  carry = wide[8];
               end
            end
            srcShift: begin
               bus = {1'b0, a[7:1]};
               carry = a[0];
            end
         endcase
         case (d)
            destPc: begin
               if (jump) begin
                  done = (bus == at);
                  pc = bus;
               end
            end
            destA:   a = bus;
            destB:   b = bus;
            destX:   x = bus;
            destRam: ram[x[3:0]] = bus;
            destQ:   expOut.push_back(bus);
            default: ;
         endcase
      end
      return steps;
   endfunction

   task automatic runTest(input int idx);
      int         errBefore;
      logic [7:0] lat;
      @(negedge clk);
      reset = 1'b1;
      readyMode = (idx == 4);
      holdReady = (idx == 5);  // Keeps the first byte pending across a second reset
      buildProgram(idx);
      void'(runModel());
      rxCount = 0;
      errBefore = errors;
      for (int i = 0; i < progLen; i++) begin
         progWrite = 1'b1;
         progAddr = 8'(i);
         progData = prog[i];
         @(negedge clk);
      end
      progWrite = 1'b0;
      repeat (8) @(negedge clk);
      reset = 1'b0;
      checkValue("outValid", 8'(outValid), 8'h00);
      if (idx == 5) begin
         lat = 8'd0;
         while (!outValid && lat < 8'd20) begin
            @(negedge clk);
            lat++;
         end
         checkValue("firstValidLatency", lat, 8'd2);  // No instruction before the output
         // Reset again while the byte is still pending
         reset = 1'b1;
         repeat (2) @(negedge clk);
         reset = 1'b0;
         checkValue("outValid", 8'(outValid), 8'h00);
         holdReady = 1'b0;
      end
      while (rxCount < expOut.size()) begin
         @(negedge clk);
      end
      repeat (4) @(negedge clk);  // Room for a duplicate byte to show up
      $display("Test %0d %s: %0d bytes, %0d errors", idx, testNames[idx], expOut.size(),
               errors - errBefore);
   endtask

   always @(negedge clk) begin
      rnd = $random(seed);
      stretchCnt <= stretchCnt + 4'd1;
      if (holdReady || (readyMode && stretchCnt < 4'd7)) begin
         outReady <= 1'b0;
      end else begin
         outReady <= rnd[0];
      end
   end

   // Output checker
   always @(posedge clk) begin
      if (!reset && outValid && outReady) begin
         if (rxCount < expOut.size()) begin
            checkValue("outData", outData, expOut[rxCount]);
         end else begin
            $display("Extra output byte 0x%02h after all %0d expected bytes", outData,
                     expOut.size());
            errors++;
         end
         rxCount++;
      end
   end

   always @(posedge clk) begin
      if (!reset) begin
         cycles <= cycles + 1;
         if (cycles >= limit) begin
            $display("Timeout after %0d cycles, the outputs stopped arriving", cycles);
            $display("Regression failed");
            $finish;
         end
      end
   end

   initial begin
      int total;
      reset = 1'b1;
      progWrite = 1'b0;
      progAddr = '0;
      progData = '0;
      total = 0;
      for (int t = 0; t < numTests; t++) begin
         buildProgram(t);
         total += 2 * runModel();
      end
      limit = 4 * total + 50;
      for (int t = 0; t < numTests; t++) begin
         runTest(t);
      end
      $display("Tests %0d, checks %0d, errors %0d", numTests, checks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* ttlCpu.f */
rtl/ttlCpuPkg.sv
rtl/programStore.sv
rtl/sequencer.sv
rtl/controlDecode.sv
rtl/dataPath.sv
rtl/outputPort.sv
rtl/ttlCpu.sv
tb/ttlCpuTb.sv

/* run.sh */
#!/bin/sh
# Build and run the ttlCpu regression with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f ttlCpu.f --top-module ttlCpuTb -o ttlCpuSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/ttlCpuSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
   exit 0
fi
exit 1
